/* design/router_settings.svh */
/* compile-time sizes for the ring router
   include this wherever a width, depth or ring constant is needed */

`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// message field widths
`define ROUTER_PAYLOAD_NBITS 32
`define ROUTER_OPAQUE_NBITS 3
`define ROUTER_SRCDEST_NBITS 3

// ring geometry
`define ROUTER_NUM_ROUTERS 8
`define ROUTER_DEFAULT_ID 0

// input buffering
// free count must hold 0..depth
`define ROUTER_QUEUE_DEPTH 4
`define ROUTER_FREE_NBITS 3

`endif

/* design/router_pkg.sv */
/* shared types of the ring router
   message word, port names and queue free counts */

`include "router_settings.svh"

package router_pkg;

  // ------------------------------
  // network message
  // ------------------------------

  // dest sits in the top bits, payload in the bottom bits
  typedef struct packed {
    logic [`ROUTER_SRCDEST_NBITS-1:0] dest;
    logic [`ROUTER_SRCDEST_NBITS-1:0] src;
    logic [`ROUTER_OPAQUE_NBITS-1:0]  opaque;
    logic [`ROUTER_PAYLOAD_NBITS-1:0] payload;
  } net_msg_t;

  // ------------------------------
  // ports
  // ------------------------------

  // used both as crossbar select and grant index
  typedef enum logic [1:0] {
    PORT_WEST = 2'd0,
    PORT_TERM = 2'd1,
    PORT_EAST = 2'd2
  } port_e;

  // free entries left in an input queue
  typedef logic [`ROUTER_FREE_NBITS-1:0] free_cnt_t;

endpackage

/* design/port_deq_if.sv */
/* dequeue side of one router input port
   the port presents its head message, the control strobes rdy */

interface port_deq_if;

  // head of the current-domain queue
  logic                  val;
  router_pkg::net_msg_t  msg;
  router_pkg::free_cnt_t free;

  // dequeue strobe from the control
  logic                  rdy;

  modport port (
    output val,
    output msg,
    output free,
    input  rdy
  );

  modport ctrl (
    input  val,
    input  msg,
    input  free,
    output rdy
  );

endinterface

/* design/msg_queue.sv */
/* circular-buffer message FIFO with a free-entry count
   depth must be a power of two, no enqueue-to-dequeue bypass */

`include "router_settings.svh"

module msg_queue #(
  parameter int depth = `ROUTER_QUEUE_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enq_val,
  output logic                  enq_rdy,
  input  router_pkg::net_msg_t  enq_msg,
  output logic                  deq_val,
  input  logic                  deq_rdy,
  output router_pkg::net_msg_t  deq_msg,
  output router_pkg::free_cnt_t free
);

  localparam int ptr_nbits = $clog2(depth);
  localparam int cnt_nbits = $clog2(depth + 1);

  router_pkg::net_msg_t mem [depth];
  logic [ptr_nbits-1:0] wr_ptr;
  logic [ptr_nbits-1:0] rd_ptr;
  logic [cnt_nbits-1:0] count;
  logic                 full;
  logic                 empty;
  logic                 do_enq;
  logic                 do_deq;

  assign full    = (count == cnt_nbits'(depth));
  assign empty   = (count == '0);
  assign enq_rdy = !full;
  assign deq_val = !empty;
  assign deq_msg = mem[rd_ptr];
  assign free    = router_pkg::free_cnt_t'(cnt_nbits'(depth) - count);

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/domain_input_port.sv */
/* ring input port with one queue per security domain
   arrivals are steered by their own domain, departures by the current one */

module domain_input_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  router_pkg::net_msg_t in_msg,
  input  logic                 in_sd,
  input  logic                 cur_sd,
  port_deq_if.port             deq
);

  logic [1:0]            q_enq_val;
  logic [1:0]            q_enq_rdy;
  logic [1:0]            q_deq_val;
  logic [1:0]            q_deq_rdy;
  router_pkg::net_msg_t  q_deq_msg [2];
  router_pkg::free_cnt_t q_free [2];

  // ------------------------------
  // per-domain queues
  // ------------------------------

  for (genvar d = 0; d < 2; d++) begin : g_dom
    assign q_enq_val[d] = in_val && (in_sd == 1'(d));
    // only the queue of the current domain sees the strobe
    assign q_deq_rdy[d] = deq.rdy && (cur_sd == 1'(d));

    msg_queue i_queue (
      .clk     (clk),
      .rst_n   (rst_n),
      .enq_val (q_enq_val[d]),
      .enq_rdy (q_enq_rdy[d]),
      .enq_msg (in_msg),
      .deq_val (q_deq_val[d]),
      .deq_rdy (q_deq_rdy[d]),
      .deq_msg (q_deq_msg[d]),
      .free    (q_free[d])
    );
  end

  // sender sees the queue it is writing
  assign in_rdy = q_enq_rdy[in_sd];

  // ------------------------------
  // dequeue side
  // ------------------------------

  assign deq.val  = q_deq_val[cur_sd];
  assign deq.msg  = q_deq_msg[cur_sd];
  assign deq.free = q_free[cur_sd];

endmodule

/* design/terminal_input_port.sv */
/* terminal input port with a single queue
   its messages may only leave in cycles of the terminal's domain */

module terminal_input_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  router_pkg::net_msg_t in_msg,
  input  logic                 in_sd,
  input  logic                 cur_sd,
  port_deq_if.port             deq
);

  logic q_deq_val;
  logic q_deq_rdy;
  logic own_slot;

  // terminal domain matches the router domain this cycle
  assign own_slot  = (cur_sd == in_sd);
  assign deq.val   = q_deq_val && own_slot;
  assign q_deq_rdy = deq.rdy && own_slot;

  msg_queue i_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_val (in_val),
    .enq_rdy (in_rdy),
    .enq_msg (in_msg),
    .deq_val (q_deq_val),
    .deq_rdy (q_deq_rdy),
    .deq_msg (deq.msg),
    .free    (deq.free)
  );

endmodule

/* design/router_ctrl.sv */
/* router control: domain register, route computation and round-robin
   output arbitration, drives the dequeue strobes and crossbar selects */

`include "router_settings.svh"

module router_ctrl #(
  parameter int router_id = `ROUTER_DEFAULT_ID
) (
  input  logic              clk,
  input  logic              rst_n,
  port_deq_if.ctrl          west,
  port_deq_if.ctrl          term,
  port_deq_if.ctrl          east,
  output logic              cur_sd,
  output logic [2:0]        out_val,
  input  logic [2:0]        out_rdy,
  output router_pkg::port_e xbar_sel [3]
);

  localparam int num_routers = `ROUTER_NUM_ROUTERS;

  logic [2:0]           in_val;
  logic [2:0]           in_rdy;
  // req[i][o] set when input i wants output o
  logic [2:0]           req [3];
  logic [2:0]           xfer;

  function automatic logic [2:0] port_bit(router_pkg::port_e p);
    return 3'b001 << p;
  endfunction

  function automatic router_pkg::port_e next_port(router_pkg::port_e p);
    return (p == router_pkg::PORT_EAST) ? router_pkg::PORT_WEST
                                        : router_pkg::port_e'(p + 2'd1);
  endfunction

  // shorter way round the ring
  // a tie goes to the emptier side and then east
  function automatic router_pkg::port_e term_route(
    router_pkg::net_msg_t  msg,
    router_pkg::free_cnt_t free_w,
    router_pkg::free_cnt_t free_e
  );
    int dist_e;
    int dist_w;
    dist_e = (int'(msg.dest) + num_routers - router_id) % num_routers;
    dist_w = (router_id + num_routers - int'(msg.dest)) % num_routers;
    if (int'(msg.dest) == router_id) begin
      return router_pkg::PORT_TERM;
    end
    if (dist_e < dist_w) begin
      return router_pkg::PORT_EAST;
    end
    if (dist_w < dist_e) begin
      return router_pkg::PORT_WEST;
    end
    return (free_w > free_e) ? router_pkg::PORT_WEST : router_pkg::PORT_EAST;
  endfunction

  // ------------------------------
  // input gathering
  // ------------------------------

  assign in_val = {east.val, term.val, west.val};

  assign west.rdy = in_rdy[router_pkg::PORT_WEST];
  assign term.rdy = in_rdy[router_pkg::PORT_TERM];
  assign east.rdy = in_rdy[router_pkg::PORT_EAST];

  // ------------------------------
  // route computation
  // ------------------------------

  // ring traffic only ejects or passes through
  always_comb begin
    req[router_pkg::PORT_WEST] = '0;
    req[router_pkg::PORT_TERM] = '0;
    req[router_pkg::PORT_EAST] = '0;
    if (in_val[router_pkg::PORT_WEST]) begin
      req[router_pkg::PORT_WEST] =
        port_bit((int'(west.msg.dest) == router_id) ? router_pkg::PORT_TERM
                                                    : router_pkg::PORT_EAST);
    end
    if (in_val[router_pkg::PORT_EAST]) begin
      req[router_pkg::PORT_EAST] =
        port_bit((int'(east.msg.dest) == router_id) ? router_pkg::PORT_TERM
                                                    : router_pkg::PORT_WEST);
    end
    if (in_val[router_pkg::PORT_TERM]) begin
      req[router_pkg::PORT_TERM] = port_bit(term_route(term.msg, west.free, east.free));
    end
  end

  // ------------------------------
  // output arbiters
  // ------------------------------

  for (genvar o = 0; o < 3; o++) begin : g_arb
    logic [2:0]        reqs;
    logic              granted;
    router_pkg::port_e winner;
    router_pkg::port_e prio;

    assign reqs = {req[2][o], req[1][o], req[0][o]};

    // scan from the lowest priority so the pointer's own slot wins last
    always_comb begin
      int idx;
      winner  = prio;
      granted = 1'b0;
      for (int k = 2; k >= 0; k--) begin
        idx = (int'(prio) + k) % 3;
        if (reqs[idx]) begin
          winner  = router_pkg::port_e'(idx[1:0]);
          granted = 1'b1;
        end
      end
    end

    assign out_val[o]  = granted;
    assign xbar_sel[o] = winner;
    assign xfer[o]     = granted && out_rdy[o];

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        prio <= router_pkg::PORT_WEST;
      end else if (xfer[o]) begin
        prio <= next_port(winner);
      end
    end
  end

  // each input requests one output, so at most one strobe per input
  always_comb begin
    in_rdy = '0;
    for (int o = 0; o < 3; o++) begin
      if (xfer[o]) begin
        in_rdy[xbar_sel[o]] = 1'b1;
      end
    end
  end

  // domain flips every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_sd <= 1'b0;
    end else begin
      cur_sd <= ~cur_sd;
    end
  end

endmodule

/* design/router_crossbar.sv */
/* three-by-three message crossbar
   each output picks the input named by its select */

module router_crossbar (
  input  router_pkg::net_msg_t in_msg [3],
  input  router_pkg::port_e    sel [3],
  output router_pkg::net_msg_t out_msg [3]
);

  // one mux per output
  always_comb begin
    for (int o = 0; o < 3; o++) begin
      case (sel[o])
        router_pkg::PORT_WEST: out_msg[o] = in_msg[router_pkg::PORT_WEST];
        router_pkg::PORT_TERM: out_msg[o] = in_msg[router_pkg::PORT_TERM];
        router_pkg::PORT_EAST: out_msg[o] = in_msg[router_pkg::PORT_EAST];
        default:               out_msg[o] = '0;
      endcase
    end
  end

endmodule

/* design/ring_router.sv */
/* ring router top level with west, terminal and east ports
   every output reports the domain of the cycle it leaves in */

`include "router_settings.svh"

module ring_router #(
  parameter int router_id = `ROUTER_DEFAULT_ID
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 west_in_val,
  output logic                 west_in_rdy,
  input  router_pkg::net_msg_t west_in_msg,
  input  logic                 west_in_sd,
  input  logic                 term_in_val,
  output logic                 term_in_rdy,
  input  router_pkg::net_msg_t term_in_msg,
  input  logic                 term_in_sd,
  input  logic                 east_in_val,
  output logic                 east_in_rdy,
  input  router_pkg::net_msg_t east_in_msg,
  input  logic                 east_in_sd,

  output logic                 west_out_val,
  input  logic                 west_out_rdy,
  output router_pkg::net_msg_t west_out_msg,
  output logic                 west_out_sd,
  output logic                 term_out_val,
  input  logic                 term_out_rdy,
  output router_pkg::net_msg_t term_out_msg,
  output logic                 term_out_sd,
  output logic                 east_out_val,
  input  logic                 east_out_rdy,
  output router_pkg::net_msg_t east_out_msg,
  output logic                 east_out_sd
);

  logic                 cur_sd;
  logic [2:0]           out_val;
  router_pkg::port_e    xbar_sel [3];
  router_pkg::net_msg_t xbar_in [3];
  router_pkg::net_msg_t xbar_out [3];

  port_deq_if west_deq ();
  port_deq_if term_deq ();
  port_deq_if east_deq ();

  // ------------------------------
  // input ports
  // ------------------------------

  domain_input_port i_west_port (
    .clk (clk), .rst_n (rst_n),
    .in_val (west_in_val), .in_rdy (west_in_rdy),
    .in_msg (west_in_msg), .in_sd (west_in_sd),
    .cur_sd (cur_sd), .deq (west_deq)
  );

  terminal_input_port i_term_port (
    .clk (clk), .rst_n (rst_n),
    .in_val (term_in_val), .in_rdy (term_in_rdy),
    .in_msg (term_in_msg), .in_sd (term_in_sd),
    .cur_sd (cur_sd), .deq (term_deq)
  );

  domain_input_port i_east_port (
    .clk (clk), .rst_n (rst_n),
    .in_val (east_in_val), .in_rdy (east_in_rdy),
    .in_msg (east_in_msg), .in_sd (east_in_sd),
    .cur_sd (cur_sd), .deq (east_deq)
  );

  // ------------------------------
  // control and crossbar
  // ------------------------------

  router_ctrl #(.router_id(router_id)) i_ctrl (
    .clk (clk), .rst_n (rst_n),
    .west (west_deq), .term (term_deq), .east (east_deq),
    .cur_sd (cur_sd), .out_val (out_val),
    .out_rdy ({east_out_rdy, term_out_rdy, west_out_rdy}),
    .xbar_sel (xbar_sel)
  );

  assign xbar_in[router_pkg::PORT_WEST] = west_deq.msg;
  assign xbar_in[router_pkg::PORT_TERM] = term_deq.msg;
  assign xbar_in[router_pkg::PORT_EAST] = east_deq.msg;

  router_crossbar i_xbar (
    .in_msg (xbar_in), .sel (xbar_sel), .out_msg (xbar_out)
  );

  assign west_out_val = out_val[router_pkg::PORT_WEST];
  assign term_out_val = out_val[router_pkg::PORT_TERM];
  assign east_out_val = out_val[router_pkg::PORT_EAST];
  assign west_out_msg = xbar_out[router_pkg::PORT_WEST];
  assign term_out_msg = xbar_out[router_pkg::PORT_TERM];
  assign east_out_msg = xbar_out[router_pkg::PORT_EAST];
  assign west_out_sd  = cur_sd;
  assign term_out_sd  = cur_sd;
  assign east_out_sd  = cur_sd;

endmodule

/* tests/router_tb.sv */
/* directed testbench for the ring router at router id 2
   drives the three inputs, collects the three outputs and checks routes and domains */

module router_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int tb_router_id = 2;
  // roughly 600 cycles of tests with a wide margin
  localparam int cycle_limit  = 4000;
  localparam int drain_limit  = 200;

  logic                 clk;
  logic                 rst_n;
  // all port arrays are indexed by port_e
  logic                 in_val [3];
  logic                 in_rdy [3];
  router_pkg::net_msg_t in_msg [3];
  logic                 in_sd [3];
  logic                 out_val [3];
  logic                 out_rdy [3];
  router_pkg::net_msg_t out_msg [3];
  logic                 out_sd [3];

  router_pkg::net_msg_t exp_msg [3][$];
  bit                   exp_sd [3][$];
  router_pkg::net_msg_t got_msg [3][$];
  bit                   got_sd [3][$];

  int    err_msg = 0;
  int    err_sd = 0;
  int    err_other = 0;
  int    cycle_count = 0;
  string current_test = "reset";

  ring_router #(.router_id(tb_router_id)) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .west_in_val  (in_val[0]),
    .west_in_rdy  (in_rdy[0]),
    .west_in_msg  (in_msg[0]),
    .west_in_sd   (in_sd[0]),
    .term_in_val  (in_val[1]),
    .term_in_rdy  (in_rdy[1]),
    .term_in_msg  (in_msg[1]),
    .term_in_sd   (in_sd[1]),
    .east_in_val  (in_val[2]),
    .east_in_rdy  (in_rdy[2]),
    .east_in_msg  (in_msg[2]),
    .east_in_sd   (in_sd[2]),
    .west_out_val (out_val[0]),
    .west_out_rdy (out_rdy[0]),
    .west_out_msg (out_msg[0]),
    .west_out_sd  (out_sd[0]),
    .term_out_val (out_val[1]),
    .term_out_rdy (out_rdy[1]),
    .term_out_msg (out_msg[1]),
    .term_out_sd  (out_sd[1]),
    .east_out_val (out_val[2]),
    .east_out_rdy (out_rdy[2]),
    .east_out_msg (out_msg[2]),
    .east_out_sd  (out_sd[2])
  );

  always #20 clk = ~clk;

  // a message is taken when val and rdy meet at an edge
  always @(posedge clk) begin
    for (int o = 0; o < 3; o++) begin
      if (rst_n && out_val[o] && out_rdy[o]) begin
        got_msg[o].push_back(out_msg[o]);
        got_sd[o].push_back(out_sd[o]);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles in test %s", cycle_count, current_test);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------
  // reference model and helpers
  // ------------------------------

  function automatic string port_name(int p);
    case (p)
      0:       return "west";
      1:       return "terminal";
      default: return "east";
    endcase
  endfunction

  // east is the direction of rising router ids
  function automatic router_pkg::port_e expected_out(router_pkg::port_e src,
                                                     router_pkg::net_msg_t m);
    int hops_e;
    int hops_w;
    hops_e = (int'(m.dest) - tb_router_id + 8) % 8;
    hops_w = (8 - hops_e) % 8;
    if (int'(m.dest) == tb_router_id) return router_pkg::PORT_TERM;
    if (src == router_pkg::PORT_WEST) return router_pkg::PORT_EAST;
    if (src == router_pkg::PORT_EAST) return router_pkg::PORT_WEST;
    if (hops_e < hops_w) return router_pkg::PORT_EAST;
    if (hops_w < hops_e) return router_pkg::PORT_WEST;
    // tie only tested with both ring queues empty
    return router_pkg::PORT_EAST;
  endfunction

  // opaque tags the message with its input port and domain
  function automatic router_pkg::net_msg_t make_msg(router_pkg::port_e p, logic [2:0] dest,
                                                    bit sd);
    router_pkg::net_msg_t m;
    m.dest    = dest;
    m.src     = 3'(p);
    m.opaque  = {sd, 2'(p)};
    m.payload = $urandom;
    return m;
  endfunction

  task automatic check_msg(string test, router_pkg::net_msg_t exp, router_pkg::net_msg_t act);
    if (act !== exp) begin
      err_msg++;
      $display("mismatch %s: expected msg %h, actual %h", test, exp, act);
    end
  endtask

  task automatic check_sd(string test, bit exp, bit act);
    if (act !== exp) begin
      err_sd++;
      $display("mismatch %s: expected sd %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic send(router_pkg::port_e p, router_pkg::net_msg_t m, bit sd);
    in_val[p] <= 1'b1;
    in_msg[p] <= m;
    in_sd[p]  <= sd;
    @(posedge clk);
    while (!in_rdy[p]) @(posedge clk);
    in_val[p] <= 1'b0;
  endtask

  task automatic send_expect(router_pkg::port_e p, logic [2:0] dest, bit sd);
    router_pkg::net_msg_t m;
    router_pkg::port_e    o;
    m = make_msg(p, dest, sd);
    o = expected_out(p, m);
    exp_msg[o].push_back(m);
    exp_sd[o].push_back(sd);
    send(p, m, sd);
  endtask

  task automatic clear_queues(string test);
    current_test = test;
    for (int o = 0; o < 3; o++) begin
      exp_msg[o].delete();
      exp_sd[o].delete();
      got_msg[o].delete();
      got_sd[o].delete();
    end
  endtask

  function automatic bit all_arrived();
    for (int o = 0; o < 3; o++) begin
      if (got_msg[o].size() < exp_msg[o].size()) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic wait_drain(string test);
    int waited;
    waited = 0;
    while (!all_arrived() && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (!all_arrived()) begin
      err_other++;
      $display("test %s: messages still missing after %0d cycles", test, drain_limit);
    end
    // room for any extra message to show up
    repeat (4) @(posedge clk);
  endtask

  // order holds per output for each input and domain, so compare by opaque tag
  task automatic check_outputs(string test);
    router_pkg::net_msg_t em [$];
    router_pkg::net_msg_t am [$];
    router_pkg::net_msg_t m;
    bit                   es [$];
    bit                   act_sd [$];
    for (int o = 0; o < 3; o++) begin
      for (int key = 0; key < 8; key++) begin
        em.delete();
        am.delete();
        es.delete();
        act_sd.delete();
        for (int i = 0; i < exp_msg[o].size(); i++) begin
          m = exp_msg[o][i];
          if (m.opaque == 3'(key)) begin
            em.push_back(m);
            es.push_back(exp_sd[o][i]);
          end
        end
        for (int i = 0; i < got_msg[o].size(); i++) begin
          m = got_msg[o][i];
          if (m.opaque == 3'(key)) begin
            am.push_back(m);
            act_sd.push_back(got_sd[o][i]);
          end
        end
        if (em.size() != am.size()) begin
          err_other++;
          $display("test %s: %s output carried %0d messages from %s input in domain %0d, not %0d",
                   test, port_name(o), am.size(), port_name(key % 4), key / 4, em.size());
        end
        for (int i = 0; i < em.size() && i < am.size(); i++) begin
          check_msg(test, em[i], am[i]);
          check_sd(test, es[i], act_sd[i]);
        end
      end
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic term_local();
    clear_queues("term_local");
    for (int i = 0; i < 3; i++) send_expect(router_pkg::PORT_TERM, 3'd2, 1'b0);
    wait_drain("term_local");
    // switch domain only once the queue is empty
    for (int i = 0; i < 3; i++) send_expect(router_pkg::PORT_TERM, 3'd2, 1'b1);
    wait_drain("term_local");
    check_outputs("term_local");
  endtask

  task automatic term_route();
    int dests [5] = '{3, 5, 1, 7, 6};
    clear_queues("term_route");
    for (int i = 0; i < 5; i++) send_expect(router_pkg::PORT_TERM, 3'(dests[i]), 1'b0);
    wait_drain("term_route");
    check_outputs("term_route");
  endtask

  task automatic pass_through();
    clear_queues("pass_through");
    for (int i = 0; i < 8; i++) send_expect(router_pkg::PORT_WEST, 3'(i), i[0]);
    for (int i = 0; i < 8; i++) send_expect(router_pkg::PORT_EAST, 3'(7 - i), !i[0]);
    wait_drain("pass_through");
    check_outputs("pass_through");
  endtask

  task automatic domain_split();
    clear_queues("domain_split");
    for (int i = 0; i < 10; i++) send_expect(router_pkg::PORT_WEST, 3'd5, i[0]);
    wait_drain("domain_split");
    check_outputs("domain_split");
  endtask

  task automatic back_pressure();
    bit seen_val;
    clear_queues("back_pressure");
    out_rdy[router_pkg::PORT_EAST] <= 1'b0;
    for (int i = 0; i < 4; i++) send_expect(router_pkg::PORT_WEST, 3'd5, 1'b0);
    @(posedge clk);
    if (in_rdy[router_pkg::PORT_WEST]) begin
      err_other++;
      $display("test back_pressure: west input still ready with its queue full");
    end
    // the held head waits on the east output in domain-0 cycles
    seen_val = 1'b0;
    repeat (2) begin
      @(posedge clk);
      if (out_val[router_pkg::PORT_EAST]) begin
        seen_val = 1'b1;
        check_msg("back_pressure", exp_msg[router_pkg::PORT_EAST][0],
                  out_msg[router_pkg::PORT_EAST]);
        check_sd("back_pressure", 1'b0, out_sd[router_pkg::PORT_EAST]);
      end
    end
    if (!seen_val) begin
      err_other++;
      $display("test back_pressure: east output never offered the held message");
    end
    fork
      begin
        for (int i = 0; i < 2; i++) send_expect(router_pkg::PORT_WEST, 3'd5, 1'b0);
      end
      begin
        repeat (10) @(posedge clk);
        out_rdy[router_pkg::PORT_EAST] <= 1'b1;
      end
    join
    wait_drain("back_pressure");
    check_outputs("back_pressure");
  endtask

  task automatic contention();
    router_pkg::net_msg_t m;
    int first_w;
    int last_w;
    int first_t;
    int last_t;
    clear_queues("contention");
    fork
      begin
        for (int i = 0; i < 6; i++) send_expect(router_pkg::PORT_WEST, 3'd4, 1'b0);
      end
      begin
        for (int i = 0; i < 6; i++) send_expect(router_pkg::PORT_TERM, 3'd4, 1'b0);
      end
    join
    wait_drain("contention");
    check_outputs("contention");
    first_w = -1;
    last_w  = -1;
    first_t = -1;
    last_t  = -1;
    for (int i = 0; i < got_msg[router_pkg::PORT_EAST].size(); i++) begin
      m = got_msg[router_pkg::PORT_EAST][i];
      if (m.opaque[1:0] == 2'd0) begin
        if (first_w < 0) first_w = i;
        last_w = i;
      end else if (m.opaque[1:0] == 2'd1) begin
        if (first_t < 0) first_t = i;
        last_t = i;
      end
    end
    if (first_w < 0 || first_t < 0 || first_t > last_w || first_w > last_t) begin
      err_other++;
      $display("test contention: one input was not served until the other burst finished");
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    void'($urandom(32'h1254c9f8));
    clk   = 1'b0;
    rst_n <= 1'b0;
    for (int p = 0; p < 3; p++) begin
      in_val[p]  <= 1'b0;
      in_msg[p]  <= '0;
      in_sd[p]   <= 1'b0;
      out_rdy[p] <= 1'b1;
    end
    repeat (10) @(posedge clk);
    // domain register starts at 0 with nothing to send
    check_sd("reset", 1'b0, out_sd[router_pkg::PORT_WEST]);
    if (out_val[0] || out_val[1] || out_val[2]) begin
      err_other++;
      $display("test reset: an output is valid during reset");
    end
    rst_n <= 1'b1;
    @(posedge clk);
    term_local();
    term_route();
    pass_through();
    domain_split();
    back_pressure();
    contention();
    $display("errors: msg %0d, sd %0d, other %0d", err_msg, err_sd, err_other);
    if (err_msg + err_sd + err_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+design
design/router_pkg.sv
design/port_deq_if.sv
design/msg_queue.sv
design/domain_input_port.sv
design/terminal_input_port.sv
design/router_ctrl.sv
design/router_crossbar.sv
design/ring_router.sv
tests/router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the router testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f project.f --top-module router_tb -o router_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/router_sim | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
